// File: hw/nexus_pkg.sv
// Nexus controller shared definitions

package nexus_pkg;

  // Register file geometry
  localparam int REG_COUNT = 16;
  localparam int ADDR_W = 4;

  // Number of clk_i cycles per UART bit
  localparam int UART_CLKS_PER_BIT = 16;
  // Width of the UART bit-period counter
  localparam int UART_CNT_W = $clog2(UART_CLKS_PER_BIT);
  // Start bit, eight data bits and one stop bit
  localparam int UART_FRAME_BITS = 10;

  // Depth of the SPI pin synchronizer
  localparam int SYNC_STAGES = 2;

  // Command opcodes carried in the first byte of every SPI frame
  // Values outside this list are illegal and raise the fault flag
  typedef enum logic [7:0] {
    OP_WRITE  = 8'h01,
    OP_READ   = 8'h02,
    OP_SEND   = 8'h03,
    OP_HALT   = 8'h04,
    OP_RESUME = 8'h05
  } opcode_e;

  // Position of the decoder inside an SPI frame
  typedef enum logic [1:0] {
    ST_OPCODE,
    ST_ADDR,
    ST_DATA,
    ST_IGNORE
  } dec_state_e;

  // One received SPI byte
  // The first flag marks the opening byte after chip select falls
  typedef struct packed {
    logic       first;
    logic [7:0] data;
  } spi_byte_t;

  // One complete command as seen by the execute stage
  // Address_bad is set when the upper nibble of the address byte is nonzero
  typedef struct packed {
    opcode_e             opcode;
    logic [ADDR_W-1:0]   address;
    logic [7:0]          data;
    logic                address_bad;
  } cmd_t;

endpackage

// File: hw/spi_target.sv
// SPI target byte engine
`timescale 1ns/1ns

module spi_target (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 spi_clk_i,
  input  logic                 spi_csb_i,
  input  logic                 spi_mosi_i,
  input  logic [7:0]           reply_i,
  output logic                 spi_miso_o,
  output logic                 byte_valid_o,
  output nexus_pkg::spi_byte_t byte_o
);

  // Synchronizer chain for SPI clock, chip select and MOSI, in that bit order
  logic [nexus_pkg::SYNC_STAGES-1:0][2:0] pin_sync;
  logic       sclk_s;
  logic       csb_s;
  logic       mosi_s;
  // Previous synchronized levels for edge detection
  logic       sclk_q;
  logic       csb_q;
  // Registered edge events, one cycle behind the synchronizer output
  logic       rise_q;
  logic       fall_q;
  logic       cs_start_q;
  logic       mosi_q;
  // Receive and transmit shift registers
  logic [2:0] bit_cnt;
  logic [7:0] rx_shift;
  logic [7:0] tx_shift;
  logic       first_pend;

  assign {sclk_s, csb_s, mosi_s} = pin_sync[nexus_pkg::SYNC_STAGES-1];

  // MISO always shows the top bit of the transmit register
  assign spi_miso_o = tx_shift[7];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      // Idle pin levels are clock low and chip select high
      pin_sync     <= {nexus_pkg::SYNC_STAGES{3'b010}};
      sclk_q       <= 1'b0;
      csb_q        <= 1'b1;
      rise_q       <= 1'b0;
      fall_q       <= 1'b0;
      cs_start_q   <= 1'b0;
      bit_cnt      <= 3'd0;
      first_pend   <= 1'b1;
      tx_shift     <= 8'h00;
      byte_valid_o <= 1'b0;
    end else begin
      pin_sync   <= {pin_sync[nexus_pkg::SYNC_STAGES-2:0], {spi_clk_i, spi_csb_i, spi_mosi_i}};
      sclk_q     <= sclk_s;
      csb_q      <= csb_s;
      // SPI clock edges only count while the target is selected
      rise_q     <= sclk_s & ~sclk_q & ~csb_s;
      fall_q     <= ~sclk_s & sclk_q & ~csb_s;
      cs_start_q <= csb_q & ~csb_s;

      byte_valid_o <= 1'b0;
      if (csb_s) begin
        // Deselect rewinds the bit counter and arms the first-byte flag
        bit_cnt    <= 3'd0;
        first_pend <= 1'b1;
      end else if (rise_q) begin
        bit_cnt <= bit_cnt + 3'd1;
        if (bit_cnt == 3'd7) begin
          byte_valid_o <= 1'b1;
          first_pend   <= 1'b0;
        end
      end

      // A byte starts at chip select fall or at the falling edge after bit eight
      if (cs_start_q) begin
        tx_shift <= reply_i;
      end else if (fall_q) begin
        if (bit_cnt == 3'd0) begin
          tx_shift <= reply_i;
        end else begin
          tx_shift <= {tx_shift[6:0], 1'b0};
        end
      end
    end
  end

  // Received data path, MSB first
  always_ff @(posedge clk_i) begin
    mosi_q <= mosi_s;
    if (rise_q) begin
      rx_shift <= {rx_shift[6:0], mosi_q};
      if (bit_cnt == 3'd7) begin
        byte_o.data  <= {rx_shift[6:0], mosi_q};
        byte_o.first <= first_pend;
      end
    end
  end

endmodule

// File: hw/cmd_decoder.sv
// SPI command decoder
`timescale 1ns/1ns

module cmd_decoder (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 byte_valid_i,
  input  nexus_pkg::spi_byte_t byte_i,
  output logic                 cmd_valid_o,
  output nexus_pkg::cmd_t      cmd_o
);

  nexus_pkg::dec_state_e state;
  nexus_pkg::cmd_t       cmd_q;
  nexus_pkg::opcode_e    op_in;
  logic                  take_opcode;

  // Incoming byte viewed as an opcode
  assign op_in = nexus_pkg::opcode_e'(byte_i.data);

  // A first byte always restarts the frame whatever state was left behind
  assign take_opcode = byte_i.first || (state == nexus_pkg::ST_OPCODE);

  assign cmd_o = cmd_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state       <= nexus_pkg::ST_OPCODE;
      cmd_valid_o <= 1'b0;
    end else begin
      cmd_valid_o <= 1'b0;
      if (byte_valid_i) begin
        if (take_opcode) begin
          case (op_in)
            nexus_pkg::OP_WRITE,
            nexus_pkg::OP_READ,
            nexus_pkg::OP_SEND: state <= nexus_pkg::ST_ADDR;
            // Halt, resume and illegal opcodes go out at once
            default: begin
              cmd_valid_o <= 1'b1;
              state       <= nexus_pkg::ST_IGNORE;
            end
          endcase
        end else begin
          case (state)
            nexus_pkg::ST_ADDR: begin
              if (cmd_q.opcode == nexus_pkg::OP_WRITE) begin
                state <= nexus_pkg::ST_DATA;
              end else begin
                // Read and send are complete once the address is known
                cmd_valid_o <= 1'b1;
                state       <= nexus_pkg::ST_IGNORE;
              end
            end
            nexus_pkg::ST_DATA: begin
              cmd_valid_o <= 1'b1;
              state       <= nexus_pkg::ST_IGNORE;
            end
            // Trailing bytes are dropped until the next frame
            default: state <= nexus_pkg::ST_IGNORE;
          endcase
        end
      end
    end
  end

  // Command fields fill in as their bytes arrive
  always_ff @(posedge clk_i) begin
    if (byte_valid_i) begin
      if (take_opcode) begin
        cmd_q.opcode      <= op_in;
        cmd_q.address     <= '0;
        cmd_q.data        <= 8'h00;
        cmd_q.address_bad <= 1'b0;
      end else if (state == nexus_pkg::ST_ADDR) begin
        cmd_q.address     <= byte_i.data[nexus_pkg::ADDR_W-1:0];
        cmd_q.address_bad <= |byte_i.data[7:nexus_pkg::ADDR_W];
      end else if (state == nexus_pkg::ST_DATA) begin
        cmd_q.data <= byte_i.data;
      end
    end
  end

endmodule

// File: hw/exec_stage.sv
// Command execute stage
`timescale 1ns/1ns

module exec_stage (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            cmd_valid_i,
  input  nexus_pkg::cmd_t cmd_i,
  input  logic            tx_busy_i,
  output logic [7:0]      reply_o,
  output logic            tx_start_o,
  output logic [7:0]      tx_data_o,
  output logic            halted_o,
  output logic            fault_o
);

  logic [7:0] regs [nexus_pkg::REG_COUNT];
  logic       uses_addr;
  logic       bad_addr;
  logic       send_go;
  logic       send_drop;

  // Write, read and send all carry an address byte
  assign uses_addr = (cmd_i.opcode == nexus_pkg::OP_WRITE) ||
                     (cmd_i.opcode == nexus_pkg::OP_READ)  ||
                     (cmd_i.opcode == nexus_pkg::OP_SEND);
  assign bad_addr  = cmd_valid_i && uses_addr && cmd_i.address_bad;

  // Send is ignored while halted and dropped when the UART is still busy
  assign send_go   = cmd_valid_i && (cmd_i.opcode == nexus_pkg::OP_SEND) &&
                     !cmd_i.address_bad && !halted_o && !tx_busy_i;
  assign send_drop = cmd_valid_i && (cmd_i.opcode == nexus_pkg::OP_SEND) &&
                     !cmd_i.address_bad && !halted_o && tx_busy_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      halted_o   <= 1'b0;
      fault_o    <= 1'b0;
      tx_start_o <= 1'b0;
      reply_o    <= 8'h00;
      for (int i = 0; i < nexus_pkg::REG_COUNT; i++) begin
        regs[i] <= 8'h00;
      end
    end else begin
      tx_start_o <= send_go;
      // The fault flag is sticky until reset
      if (bad_addr || send_drop) begin
        fault_o <= 1'b1;
      end
      if (cmd_valid_i && !bad_addr) begin
        case (cmd_i.opcode)
          nexus_pkg::OP_WRITE: begin
            if (!halted_o) begin
              regs[cmd_i.address] <= cmd_i.data;
            end
          end
          // Reads work in both run and halt
          nexus_pkg::OP_READ:   reply_o  <= regs[cmd_i.address];
          nexus_pkg::OP_SEND:   ;
          nexus_pkg::OP_HALT:   halted_o <= 1'b1;
          nexus_pkg::OP_RESUME: halted_o <= 1'b0;
          default:              fault_o  <= 1'b1;
        endcase
      end
    end
  end

  // Byte handed to the UART together with the start strobe
  always_ff @(posedge clk_i) begin
    if (send_go) begin
      tx_data_o <= regs[cmd_i.address];
    end
  end

endmodule

// File: hw/uart_tx.sv
// UART 8N1 transmitter
`timescale 1ns/1ns

module uart_tx (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       start_i,
  input  logic [7:0] data_i,
  output logic       busy_o,
  output logic       tx_o
);

  logic [nexus_pkg::UART_CNT_W-1:0] clk_cnt;
  logic [3:0]                       bit_idx;
  // Remaining data bits with the stop bit on top
  logic [8:0]                       frame;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_o  <= 1'b0;
      tx_o    <= 1'b1;
      clk_cnt <= '0;
      bit_idx <= 4'd0;
    end else if (!busy_o) begin
      if (start_i) begin
        // Start bit goes out on the cycle after the strobe
        busy_o  <= 1'b1;
        tx_o    <= 1'b0;
        clk_cnt <= '0;
        bit_idx <= 4'd0;
      end
    end else if (clk_cnt == nexus_pkg::UART_CNT_W'(nexus_pkg::UART_CLKS_PER_BIT - 1)) begin
      clk_cnt <= '0;
      if (bit_idx == 4'(nexus_pkg::UART_FRAME_BITS - 1)) begin
        // Stop bit finished so the line stays idle high
        busy_o <= 1'b0;
        tx_o   <= 1'b1;
      end else begin
        bit_idx <= bit_idx + 4'd1;
        tx_o    <= frame[0];
      end
    end else begin
      clk_cnt <= clk_cnt + 1'b1;
    end
  end

  // Data leaves LSB first, the stop bit shifts down behind it
  always_ff @(posedge clk_i) begin
    if (!busy_o && start_i) begin
      frame <= {1'b1, data_i};
    end else if (busy_o &&
                 clk_cnt == nexus_pkg::UART_CNT_W'(nexus_pkg::UART_CLKS_PER_BIT - 1)) begin
      frame <= {1'b1, frame[8:1]};
    end
  end

endmodule

// File: hw/chip_nexus.sv
// Nexus controller chip top
`timescale 1ns/1ns

module chip_nexus (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic spi_clk_i,
  input  logic spi_csb_i,
  input  logic spi_mosi_i,
  output logic spi_miso_o,
  output logic uart_tx_o,
  output logic io_halted_o,
  output logic io_fault_o,
  output logic io_halted_n_o,
  output logic io_fault_n_o,
  output logic spi_clk_probe_o,
  output logic spi_csb_probe_o,
  output logic spi_mosi_probe_o,
  output logic spi_miso_probe_o
);

  nexus_pkg::spi_byte_t spi_byte;
  logic                 byte_valid;
  nexus_pkg::cmd_t      cmd;
  logic                 cmd_valid;
  logic [7:0]           reply;
  logic                 tx_start;
  logic [7:0]           tx_data;
  logic                 tx_busy;

  // SPI pins looped back for board debug
  assign spi_clk_probe_o  = spi_clk_i;
  assign spi_csb_probe_o  = spi_csb_i;
  assign spi_mosi_probe_o = spi_mosi_i;
  assign spi_miso_probe_o = spi_miso_o;

  // Inverted status copies for active-low indicators
  assign io_halted_n_o = ~io_halted_o;
  assign io_fault_n_o  = ~io_fault_o;

  spi_target i_spi_target (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .spi_clk_i    (spi_clk_i),
    .spi_csb_i    (spi_csb_i),
    .spi_mosi_i   (spi_mosi_i),
    .reply_i      (reply),
    .spi_miso_o   (spi_miso_o),
    .byte_valid_o (byte_valid),
    .byte_o       (spi_byte)
  );

  cmd_decoder i_cmd_decoder (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .byte_valid_i (byte_valid),
    .byte_i       (spi_byte),
    .cmd_valid_o  (cmd_valid),
    .cmd_o        (cmd)
  );

  exec_stage i_exec_stage (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cmd_valid_i (cmd_valid),
    .cmd_i       (cmd),
    .tx_busy_i   (tx_busy),
    .reply_o     (reply),
    .tx_start_o  (tx_start),
    .tx_data_o   (tx_data),
    .halted_o    (io_halted_o),
    .fault_o     (io_fault_o)
  );

  uart_tx i_uart_tx (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .start_i (tx_start),
    .data_i  (tx_data),
    .busy_o  (tx_busy),
    .tx_o    (uart_tx_o)
  );

endmodule

// File: verif/chip_nexus_tb.sv
// Nexus chip testbench
`timescale 1ns/1ns

module chip_nexus_tb;

  // One table row, expected values filled in from the command rules
  typedef struct packed {
    logic       pre_reset;
    logic       twice;
    logic [7:0] op;
    logic [7:0] addr;
    logic [7:0] data;
    logic [7:0] exp_reply;
    logic       exp_halted;
    logic       exp_fault;
  } entry_t;

  logic clk;
  logic rst_n;
  logic spi_clk;
  logic spi_csb;
  logic spi_mosi;
  logic spi_miso;
  logic uart_tx;
  logic halted;
  logic fault;
  logic halted_n;
  logic fault_n;
  logic clk_probe;
  logic csb_probe;
  logic mosi_probe;
  logic miso_probe;

  entry_t      entries [$];
  // Reference state of the controller
  logic [7:0]  model_regs [16];
  logic        m_halted;
  logic        m_fault;
  logic [7:0]  m_reply;
  logic [7:0]  exp_uart [$];
  logic [7:0]  uart_q [$];
  logic [31:0] seed = 32'h3eb2_6a02;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          cycle_limit = 1000000;

  chip_nexus uut (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .spi_clk_i        (spi_clk),
    .spi_csb_i        (spi_csb),
    .spi_mosi_i       (spi_mosi),
    .spi_miso_o       (spi_miso),
    .uart_tx_o        (uart_tx),
    .io_halted_o      (halted),
    .io_fault_o       (fault),
    .io_halted_n_o    (halted_n),
    .io_fault_n_o     (fault_n),
    .spi_clk_probe_o  (clk_probe),
    .spi_csb_probe_o  (csb_probe),
    .spi_mosi_probe_o (mosi_probe),
    .spi_miso_probe_o (miso_probe)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  // Appends one row and advances the reference state by the command rules
  task automatic add_entry(input logic [7:0] op, input logic [7:0] addr,
                           input logic pre_reset, input logic twice);
    entry_t     e;
    logic       bad;
    logic [7:0] data;
    seed = xorshift(seed);
    data = seed[7:0];
    if (pre_reset) begin
      foreach (model_regs[k]) model_regs[k] = 8'h00;
      m_halted = 1'b0;
      m_fault  = 1'b0;
      m_reply  = 8'h00;
    end
    // A nonzero upper address nibble faults and suppresses the command
    bad = (addr[7:4] != 4'h0);
    case (op)
      nexus_pkg::OP_WRITE: begin
        if (bad) m_fault = 1'b1;
        else if (!m_halted) model_regs[addr[3:0]] = data;
      end
      nexus_pkg::OP_READ: begin
        if (bad) m_fault = 1'b1;
        else m_reply = model_regs[addr[3:0]];
      end
      nexus_pkg::OP_SEND: begin
        if (bad) begin
          m_fault = 1'b1;
        end else if (!m_halted) begin
          exp_uart.push_back(model_regs[addr[3:0]]);
          // The repeat arrives while the UART is still busy and is dropped
          if (twice) m_fault = 1'b1;
        end
      end
      nexus_pkg::OP_HALT:   m_halted = 1'b1;
      nexus_pkg::OP_RESUME: m_halted = 1'b0;
      default:              m_fault  = 1'b1;
    endcase
    e.pre_reset  = pre_reset;
    e.twice      = twice;
    e.op         = op;
    e.addr       = addr;
    e.data       = data;
    e.exp_reply  = m_reply;
    e.exp_halted = m_halted;
    e.exp_fault  = m_fault;
    entries.push_back(e);
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
  endtask

  // SPI mode 0 host, MSB first, MISO captured just before each rising edge
  task automatic spi_frame(input logic [23:0] bytes, input int n, input int hp,
                           output logic [7:0] last_rx);
    int         b;
    int         k;
    logic [7:0] cur;
    logic [7:0] rx;
    rx = 8'h00;
    spi_csb = 1'b0;
    repeat (hp) @(negedge clk);
    for (b = 0; b < n; b++) begin
      cur = bytes[23 - 8 * b -: 8];
      for (k = 7; k >= 0; k--) begin
        spi_mosi = cur[k];
        repeat (hp) @(negedge clk);
        rx = {rx[6:0], spi_miso};
        spi_clk = 1'b1;
        repeat (hp) @(negedge clk);
        spi_clk = 1'b0;
      end
    end
    repeat (hp) @(negedge clk);
    spi_csb  = 1'b1;
    spi_mosi = 1'b0;
    repeat (hp) @(negedge clk);
    last_rx = rx;
  endtask

  // UART receiver sampling in the middle of every bit
  always begin
    logic [7:0] rx_byte;
    @(negedge uart_tx);
    repeat (8) @(negedge clk);
    if (uart_tx !== 1'b0) begin
      errors++;
      $display("UART start bit did not stay low at %0t", $time);
    end
    for (int b = 0; b < 8; b++) begin
      repeat (16) @(negedge clk);
      rx_byte[b] = uart_tx;
    end
    repeat (16) @(negedge clk);
    if (uart_tx !== 1'b1) begin
      errors++;
      $display("UART stop bit was low at %0t", $time);
    end
    uart_q.push_back(rx_byte);
  end

  // Probe loopbacks follow the SPI pins at all times
  always @(posedge clk) begin
    #2;
    if (rst_n) begin
      check("clk probe", clk_probe, spi_clk);
      check("csb probe", csb_probe, spi_csb);
      check("mosi probe", mosi_probe, spi_mosi);
      check("miso probe", miso_probe, spi_miso);
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles, the run did not complete", cycles);
      $display("tests failed");
      $finish;
    end
  end

  initial begin
    entry_t     e;
    logic [23:0] bytes;
    logic [7:0] miso_byte;
    int         n;
    int         hp;
    int         i;
    int         wait_cnt;
    clk      = 1'b0;
    rst_n    = 1'b0;
    spi_clk  = 1'b0;
    spi_csb  = 1'b1;
    spi_mosi = 1'b0;

    // Write everything, read it back, then send, halt, drop and fault cases
    for (i = 0; i < 16; i++) add_entry(nexus_pkg::OP_WRITE, 8'(i), i == 0, 1'b0);
    for (i = 0; i < 16; i++) add_entry(nexus_pkg::OP_READ, 8'(i), 1'b0, 1'b0);
    add_entry(nexus_pkg::OP_SEND, 8'h05, 1'b0, 1'b0);
    add_entry(nexus_pkg::OP_HALT, 8'h00, 1'b0, 1'b0);
    add_entry(nexus_pkg::OP_WRITE, 8'h02, 1'b0, 1'b0);
    add_entry(nexus_pkg::OP_READ, 8'h02, 1'b0, 1'b0);
    add_entry(nexus_pkg::OP_SEND, 8'h03, 1'b0, 1'b0);
    add_entry(nexus_pkg::OP_RESUME, 8'h00, 1'b0, 1'b0);
    add_entry(nexus_pkg::OP_WRITE, 8'h02, 1'b0, 1'b0);
    add_entry(nexus_pkg::OP_READ, 8'h02, 1'b0, 1'b0);
    add_entry(nexus_pkg::OP_SEND, 8'h07, 1'b0, 1'b1);
    add_entry(nexus_pkg::OP_READ, 8'h09, 1'b0, 1'b0);
    add_entry(8'hA5, 8'h00, 1'b1, 1'b0);
    add_entry(nexus_pkg::OP_READ, 8'h00, 1'b0, 1'b0);
    add_entry(nexus_pkg::OP_WRITE, 8'h13, 1'b1, 1'b0);
    add_entry(nexus_pkg::OP_READ, 8'h03, 1'b0, 1'b0);
    cycle_limit = entries.size() * 600 + 2000;

    apply_reset();
    check("uart idle after reset", uart_tx, 1'b1);
    check("miso after reset", spi_miso, 1'b0);
    check("halted after reset", halted, 1'b0);
    check("fault after reset", fault, 1'b0);

    for (i = 0; i < entries.size(); i++) begin
      e = entries[i];
      if (e.pre_reset && i != 0) apply_reset();
      case (e.op)
        nexus_pkg::OP_WRITE: n = 3;
        nexus_pkg::OP_READ:  n = 3;
        nexus_pkg::OP_SEND:  n = 2;
        default:             n = 1;
      endcase
      bytes = {e.op, e.addr, (e.op == nexus_pkg::OP_WRITE) ? e.data : 8'h00};
      // Back-to-back sends run at the fastest SPI clock to beat the UART frame
      hp = e.twice ? 4 : 8;
      spi_frame(bytes, n, hp, miso_byte);
      if (e.twice) spi_frame(bytes, n, hp, miso_byte);
      if (e.op == nexus_pkg::OP_READ) check("read reply", miso_byte, e.exp_reply);
      check("halted", halted, e.exp_halted);
      check("halted_n", halted_n, !e.exp_halted);
      check("fault", fault, e.exp_fault);
      check("fault_n", fault_n, !e.exp_fault);
    end

    wait_cnt = 0;
    while (uart_q.size() < exp_uart.size() && wait_cnt < 400) begin
      @(negedge clk);
      wait_cnt++;
    end
    for (i = 0; i < exp_uart.size(); i++) begin
      if (i >= uart_q.size()) begin
        errors++;
        $display("UART byte %0d (%02h) was never received", i, exp_uart[i]);
      end else begin
        check("uart byte", uart_q[i], exp_uart[i]);
      end
    end
    if (uart_q.size() > exp_uart.size()) begin
      errors++;
      $display("Received %0d UART bytes but only %0d were sent", uart_q.size(),
               exp_uart.size());
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: chip_nexus.f
hw/nexus_pkg.sv
hw/spi_target.sv
hw/cmd_decoder.sv
hw/exec_stage.sv
hw/uart_tx.sv
hw/chip_nexus.sv
verif/chip_nexus_tb.sv

// File: Bender.yml
package:
  name: chip_nexus

sources:
  - files:
      - hw/nexus_pkg.sv
      - hw/spi_target.sv
      - hw/cmd_decoder.sv
      - hw/exec_stage.sv
      - hw/uart_tx.sv
      - hw/chip_nexus.sv
  - target: test
    files:
      - verif/chip_nexus_tb.sv
